// File: rtl/fpu_pkg.sv
// shared fpu types and constants, compiled first and referenced by scoped names
package fpu_pkg;

  ////////////////////////////////////////
  // field widths and constants
  ////////////////////////////////////////
  localparam int FP_WIDTH   = 32;  // operand width
  localparam int EXP_WIDTH  = 8;   // exponent field
  localparam int FRAC_WIDTH = 23;  // fraction field
  localparam int EXP_BIAS   = 127; // single precision bias

  // exponent of an i2f result that needed no shift
  localparam logic [EXP_WIDTH-1:0] I2F_EXP_TOP = EXP_WIDTH'(EXP_BIAS + FP_WIDTH - 1);

  typedef logic [FP_WIDTH-1:0] fpu_word_t; // operand or result word

  // arithmetic codes, only the conversion survives
  localparam logic [2:0] I2F_CODE = 3'd4;

  // compare conditions
  localparam logic [2:0] CMP_EQ = 3'd0;
  localparam logic [2:0] CMP_NE = 3'd1;
  localparam logic [2:0] CMP_GT = 3'd2;
  localparam logic [2:0] CMP_GE = 3'd3;
  localparam logic [2:0] CMP_LT = 3'd4;
  localparam logic [2:0] CMP_LE = 3'd5;

  ////////////////////////////////////////
  // opcode word, low bits read two ways
  ////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic       valid; // bit 7, fpu op present
      logic [2:0] rsvd;  // unused
      logic       cmp;   // bit 3, clear for arithmetic
      logic [2:0] code;  // arithmetic code
    } arith_view;
    struct packed {
      logic       valid;
      logic [2:0] rsvd;
      logic       cmp;   // set for compare
      logic [2:0] cond;  // compare condition
    } cmp_view;
  } fpu_opcode_u;

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0, // ties to even
    RM_ZERO    = 2'd1, // truncate
    RM_PLUS    = 2'd2, // toward +inf
    RM_MINUS   = 2'd3  // toward -inf
  } rmode_t;

  // unpacked view of one operand
  typedef struct packed {
    logic                  sign;
    logic [EXP_WIDTH-1:0]  exponent;
    logic [FRAC_WIDTH-1:0] fraction;
    logic                  zero;  // +0 or -0
    logic                  inf;   // +inf or -inf
    logic                  snan;  // signaling nan
    logic                  qnan;  // quiet nan
  } fpu_class_t;

  typedef struct packed {
    logic invalid;
    logic inexact;
  } fpu_flags_t;

  typedef struct packed {
    fpu_word_t  value;
    fpu_flags_t flags;
  } fpu_result_t;

endpackage

// File: rtl/fpu_unpack.sv
// combinational operand classifier, one instance per source register
module fpu_unpack (
  input  fpu_pkg::fpu_word_t  word_i,  // raw single precision word
  output fpu_pkg::fpu_class_t class_o  // split fields plus class bits
);

  logic                           exp_ones;  // exponent all ones
  logic                           frac_nz;   // any fraction bit set
  logic [fpu_pkg::EXP_WIDTH-1:0]  exp_w;
  logic [fpu_pkg::FRAC_WIDTH-1:0] frac_w;

  assign exp_w  = word_i[fpu_pkg::FP_WIDTH-2 -: fpu_pkg::EXP_WIDTH];
  assign frac_w = word_i[fpu_pkg::FRAC_WIDTH-1:0];

  assign exp_ones = &exp_w;
  assign frac_nz  = |frac_w;

  always_comb begin
    class_o.sign     = word_i[fpu_pkg::FP_WIDTH-1];
    class_o.exponent = exp_w;
    class_o.fraction = frac_w;
    // sign is ignored, -0 counts as zero
    class_o.zero     = ~(|word_i[fpu_pkg::FP_WIDTH-2:0]);
    class_o.inf      = exp_ones & ~frac_nz;
    // top fraction bit picks quiet vs signaling
    class_o.qnan     = exp_ones & frac_nz & frac_w[fpu_pkg::FRAC_WIDTH-1];
    class_o.snan     = exp_ones & frac_nz & ~frac_w[fpu_pkg::FRAC_WIDTH-1];
  end

endmodule

// File: rtl/fpu_compare.sv
// registered compare unit, loads once per accepted compare and holds the flag
module fpu_compare (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                load_i,   // from sequencer on accept
  input  logic [2:0]          cond_i,   // condition from cmp view
  input  fpu_pkg::fpu_class_t a_i,
  input  fpu_pkg::fpu_class_t b_i,
  output logic                flag_o,
  output fpu_pkg::fpu_flags_t flags_o
);

  logic [fpu_pkg::FP_WIDTH-2:0] mag_a, mag_b; // exponent and fraction
  logic any_nan, any_snan;
  logic both_zero;
  logic a_eq_b, a_gt_b;
  logic ordered;   // gt/ge/lt/le
  logic flag_d;
  logic inv_d;

  assign mag_a = {a_i.exponent, a_i.fraction};
  assign mag_b = {b_i.exponent, b_i.fraction};

  assign any_snan  = a_i.snan | b_i.snan;
  assign any_nan   = any_snan | a_i.qnan | b_i.qnan;
  assign both_zero = a_i.zero & b_i.zero;

  // sign-magnitude ordering, nan handled below
  assign a_eq_b = both_zero | ((a_i.sign == b_i.sign) & (mag_a == mag_b));

  always_comb begin
    if (both_zero) begin
      a_gt_b = 1'b0;                // +0 == -0
    end else if (a_i.sign != b_i.sign) begin
      a_gt_b = ~a_i.sign;           // positive side wins
    end else if (a_i.sign) begin
      a_gt_b = mag_a < mag_b;       // both negative, order flips
    end else begin
      a_gt_b = mag_a > mag_b;
    end
  end

  always_comb begin
    case (cond_i)
      fpu_pkg::CMP_EQ: flag_d = a_eq_b;
      fpu_pkg::CMP_NE: flag_d = ~a_eq_b;
      fpu_pkg::CMP_GT: flag_d = a_gt_b;
      fpu_pkg::CMP_GE: flag_d = a_gt_b | a_eq_b;
      fpu_pkg::CMP_LT: flag_d = ~a_gt_b & ~a_eq_b;
      fpu_pkg::CMP_LE: flag_d = ~a_gt_b;
      default:         flag_d = 1'b0; // undefined conditions
    endcase
    // unordered, only ne holds
    if (any_nan) begin
      flag_d = (cond_i == fpu_pkg::CMP_NE);
    end
  end

  assign ordered = (cond_i >= fpu_pkg::CMP_GT) & (cond_i <= fpu_pkg::CMP_LE);
  assign inv_d   = (ordered & any_nan) | (~ordered & any_snan);

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      flag_o  <= 1'b0;
      flags_o <= '0;
    end else if (load_i) begin
      flag_o          <= flag_d;
      flags_o.invalid <= inv_d;
      flags_o.inexact <= 1'b0;  // compare is always exact
    end
  end

  // sequencer holds the result, so back-to-back loads mean a lost result
  assert property (@(posedge clk) disable iff (rst) load_i |=> !load_i);

endmodule

// File: rtl/fpu_seq_fsm.sv
// one-op-at-a-time sequencer, steers compare or i2f and holds results until adv
module fpu_seq_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  fpu_pkg::fpu_opcode_u op_i,
  input  logic                 norm_done_i,  // magnitude normalized or zero
  input  logic                 adv_i,        // consumer takes result
  output logic                 ready_o,
  output logic                 cmp_load_o,
  output logic                 cvt_load_o,
  output logic                 shift_step_o,
  output logic                 round_en_o,
  output logic                 arith_valid_o,
  output logic                 cmp_valid_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMP_HOLD,
    ST_CVT_NORM,
    ST_CVT_ROUND,
    ST_CVT_HOLD
  } state_t;

  state_t state_q, state_d;
  logic   op_ok;   // qualified request
  logic   is_cmp;
  logic   is_i2f;

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////
  assign op_ok  = valid_i & op_i.arith_view.valid & ~flush_i;
  assign is_cmp = op_i.cmp_view.cmp;
  assign is_i2f = ~op_i.arith_view.cmp & (op_i.arith_view.code == fpu_pkg::I2F_CODE);

  assign ready_o       = (state_q == ST_IDLE);
  assign cmp_load_o    = ready_o & op_ok & is_cmp;
  assign cvt_load_o    = ready_o & op_ok & is_i2f;  // other codes ignored
  assign shift_step_o  = (state_q == ST_CVT_NORM) & ~norm_done_i;
  assign round_en_o    = (state_q == ST_CVT_ROUND);
  assign arith_valid_o = (state_q == ST_CVT_HOLD);
  assign cmp_valid_o   = (state_q == ST_CMP_HOLD);

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmp_load_o) begin
          state_d = ST_CMP_HOLD;
        end else if (cvt_load_o) begin
          state_d = ST_CVT_NORM;
        end
      end
      ST_CMP_HOLD: begin
        if (adv_i) state_d = ST_IDLE;    // result consumed
      end
      ST_CVT_NORM: begin
        if (norm_done_i) state_d = ST_CVT_ROUND;
      end
      ST_CVT_ROUND: state_d = ST_CVT_HOLD;
      ST_CVT_HOLD: begin
        if (adv_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
    if (flush_i) state_d = ST_IDLE;       // abandon anything in flight
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // magnitude must stay normalized through the rounding cycle
  assert property (@(posedge clk) disable iff (rst) round_en_o |-> norm_done_i);

endmodule

// File: rtl/fpu_norm_counter.sv
// counts normalizing shifts of the i2f magnitude, feeds the exponent calc
module fpu_norm_counter (
  input  logic       clk,
  input  logic       rst,
  input  logic       load_i,      // new conversion
  input  logic       step_i,      // one shift made
  output logic [4:0] shift_cnt_o  // leading zeros seen so far
);

  always_ff @(posedge clk) begin
    if (rst || load_i) begin
      shift_cnt_o <= 5'd0;
    end else if (step_i) begin
      shift_cnt_o <= shift_cnt_o + 5'd1;
    end
  end

  // a nonzero magnitude reaches its top bit within 31 shifts,
  // so the datapath must stop stepping before the count wraps
  assert property (@(posedge clk) disable iff (rst) step_i |-> shift_cnt_o != 5'd31);

endmodule

// File: rtl/fpu_i2f_datapath.sv
// i2f datapath: abs value, bit-serial normalize, then round and pack
module fpu_i2f_datapath (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load_i,      // capture integer
  input  logic                 step_i,      // shift left one bit
  input  logic                 round_en_i,  // build the result
  input  fpu_pkg::fpu_word_t   int_i,       // signed 32-bit integer
  input  fpu_pkg::rmode_t      rmode_i,
  input  logic [4:0]           shift_cnt_i, // shifts made so far
  output logic                 norm_done_o,
  output fpu_pkg::fpu_result_t result_o
);

  logic                           sign_q;
  fpu_pkg::fpu_word_t             mag_q;      // magnitude under normalization
  fpu_pkg::rmode_t                rmode_q;    // mode sampled with the operand
  logic [fpu_pkg::FRAC_WIDTH:0]   mant;       // hidden bit plus fraction
  logic [fpu_pkg::FRAC_WIDTH+1:0] mant_rnd;   // extra bit for carry out
  logic                           guard;
  logic                           sticky;
  logic                           round_up;
  logic                           carry;
  logic                           mag_zero;
  logic [fpu_pkg::EXP_WIDTH-1:0]  exp_base;
  logic [fpu_pkg::EXP_WIDTH-1:0]  exp_rnd;
  logic [fpu_pkg::FRAC_WIDTH-1:0] frac_rnd;

  ////////////////////////////////////////
  // load and normalize
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (load_i) begin
      sign_q  <= int_i[fpu_pkg::FP_WIDTH-1];
      mag_q   <= int_i[fpu_pkg::FP_WIDTH-1] ? -int_i : int_i; // -2^31 stays 0x8000_0000
      rmode_q <= rmode_i;
    end else if (step_i) begin
      mag_q <= {mag_q[fpu_pkg::FP_WIDTH-2:0], 1'b0};
    end
  end

  assign mag_zero    = ~(|mag_q);
  assign norm_done_o = mag_q[fpu_pkg::FP_WIDTH-1] | mag_zero;

  ////////////////////////////////////////
  // rounding
  ////////////////////////////////////////
  assign mant   = mag_q[31:8];   // 24 kept bits
  assign guard  = mag_q[7];
  assign sticky = |mag_q[6:0];

  always_comb begin
    case (rmode_q)
      fpu_pkg::RM_NEAREST: round_up = guard & (sticky | mant[0]); // ties to even
      fpu_pkg::RM_ZERO:    round_up = 1'b0;
      fpu_pkg::RM_PLUS:    round_up = ~sign_q & (guard | sticky);
      fpu_pkg::RM_MINUS:   round_up = sign_q & (guard | sticky);
      default:             round_up = 1'b0;
    endcase
  end

  assign mant_rnd = {1'b0, mant} + {{(fpu_pkg::FRAC_WIDTH+1){1'b0}}, round_up};
  assign carry    = mant_rnd[fpu_pkg::FRAC_WIDTH+1];  // 1.111.. rolled over

  // bias + 31 - leading zeros, bumped on carry
  assign exp_base = fpu_pkg::I2F_EXP_TOP - {{(fpu_pkg::EXP_WIDTH-5){1'b0}}, shift_cnt_i};
  assign exp_rnd  = exp_base + {{(fpu_pkg::EXP_WIDTH-1){1'b0}}, carry};
  assign frac_rnd = carry ? mant_rnd[fpu_pkg::FRAC_WIDTH:1]
                          : mant_rnd[fpu_pkg::FRAC_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
    end else if (round_en_i) begin
      if (mag_zero) begin
        result_o <= '0;                          // integer 0 gives +0, exact
      end else begin
        result_o.value         <= {sign_q, exp_rnd, frac_rnd};
        result_o.flags.invalid <= 1'b0;          // i2f cannot be invalid
        result_o.flags.inexact <= guard | sticky;
      end
    end
  end

endmodule

// File: rtl/fpu_top.sv
// fpu top level with compare and i2f, ties operands and handshakes to the units
module fpu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush_i,
  input  fpu_pkg::fpu_opcode_u op_i,
  input  logic                 valid_i,
  input  fpu_pkg::fpu_word_t   rfa_i,
  input  fpu_pkg::fpu_word_t   rfb_i,
  input  fpu_pkg::rmode_t      round_mode_i,
  input  logic                 adv_i,
  output logic                 ready_o,
  output logic                 arith_valid_o,
  output fpu_pkg::fpu_result_t result_o,
  output logic                 cmp_valid_o,
  output logic                 cmp_flag_o,
  output fpu_pkg::fpu_flags_t  cmp_flags_o
);

  fpu_pkg::fpu_class_t class_a, class_b;
  logic                cmp_load;
  logic                cvt_load;
  logic                shift_step;
  logic                round_en;
  logic                norm_done;
  logic [4:0]          shift_cnt;

  ////////////////////////////////////////
  // operand analysis
  ////////////////////////////////////////
  fpu_unpack u_unpack_a (.word_i(rfa_i), .class_o(class_a));
  fpu_unpack u_unpack_b (.word_i(rfb_i), .class_o(class_b));

  fpu_compare u_compare (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .load_i  (cmp_load),
    .cond_i  (op_i.cmp_view.cond),  // compare reading of the opcode
    .a_i     (class_a),
    .b_i     (class_b),
    .flag_o  (cmp_flag_o),
    .flags_o (cmp_flags_o)
  );

  ////////////////////////////////////////
  // sequencing and conversion
  ////////////////////////////////////////
  fpu_seq_fsm u_seq (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .op_i          (op_i),
    .norm_done_i   (norm_done),
    .adv_i         (adv_i),
    .ready_o       (ready_o),
    .cmp_load_o    (cmp_load),
    .cvt_load_o    (cvt_load),
    .shift_step_o  (shift_step),
    .round_en_o    (round_en),
    .arith_valid_o (arith_valid_o),
    .cmp_valid_o   (cmp_valid_o)
  );

  fpu_norm_counter u_norm_cnt (
    .clk         (clk),
    .rst         (rst),
    .load_i      (cvt_load),
    .step_i      (shift_step),
    .shift_cnt_o (shift_cnt)
  );

  fpu_i2f_datapath u_i2f (
    .clk         (clk),
    .rst         (rst),
    .load_i      (cvt_load),
    .step_i      (shift_step),
    .round_en_i  (round_en),
    .int_i       (rfa_i),         // integer arrives on source a
    .rmode_i     (round_mode_i),
    .shift_cnt_i (shift_cnt),
    .norm_done_o (norm_done),
    .result_o    (result_o)
  );

endmodule

// File: tests/fpu_tb_vectors.svh
// vector table for the fpu testbench, included inside the testbench module
// cmp_row: name, condition, a, b, expected flag, expected invalid
// cvt_row: name, integer, rounding mode, expected word, expected inexact
`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

task automatic fill_rows();
  ////////////////////////////////////////
  // compare, ordinary values
  ////////////////////////////////////////
  rows.push_back(cmp_row("eq_1_1", fpu_pkg::CMP_EQ, 32'h3F80_0000, 32'h3F80_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("ne_1_m1", fpu_pkg::CMP_NE, 32'h3F80_0000, 32'hBF80_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("gt_m1_m2", fpu_pkg::CMP_GT, 32'hBF80_0000, 32'hC000_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("ge_m2_1", fpu_pkg::CMP_GE, 32'hC000_0000, 32'h3F80_0000, 1'b0, 1'b0));
  rows.push_back(cmp_row("lt_m3p5_0p5", fpu_pkg::CMP_LT, 32'hC060_0000, 32'h3F00_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("le_2_2", fpu_pkg::CMP_LE, 32'h4000_0000, 32'h4000_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("gt_0p5_2", fpu_pkg::CMP_GT, 32'h3F00_0000, 32'h4000_0000, 1'b0, 1'b0));
  rows.push_back(cmp_row("lt_m1_m2", fpu_pkg::CMP_LT, 32'hBF80_0000, 32'hC000_0000, 1'b0, 1'b0));
  rows.push_back(cmp_row("eq_pz_mz", fpu_pkg::CMP_EQ, 32'h0000_0000, 32'h8000_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("le_mz_pz", fpu_pkg::CMP_LE, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("gt_inf_2", fpu_pkg::CMP_GT, 32'h7F80_0000, 32'h4000_0000, 1'b1, 1'b0));
  // nan operands, qnan 7fc00000 and snan 7f800001
  rows.push_back(cmp_row("eq_qnan", fpu_pkg::CMP_EQ, 32'h7FC0_0000, 32'h3F80_0000, 1'b0, 1'b0));
  rows.push_back(cmp_row("ne_qnan", fpu_pkg::CMP_NE, 32'h3F80_0000, 32'h7FC0_0000, 1'b1, 1'b0));
  rows.push_back(cmp_row("lt_qnan", fpu_pkg::CMP_LT, 32'h7FC0_0000, 32'h3F80_0000, 1'b0, 1'b1));
  rows.push_back(cmp_row("ge_qnan", fpu_pkg::CMP_GE, 32'h3F80_0000, 32'h7FC0_0000, 1'b0, 1'b1));
  rows.push_back(cmp_row("eq_snan", fpu_pkg::CMP_EQ, 32'h7F80_0001, 32'h3F80_0000, 1'b0, 1'b1));
  rows.push_back(cmp_row("ne_snan", fpu_pkg::CMP_NE, 32'h7F80_0001, 32'h7F80_0001, 1'b1, 1'b1));

  ////////////////////////////////////////
  // i2f, exact then rounded
  ////////////////////////////////////////
  rows.push_back(cvt_row("i2f_zero", 32'h0000_0000, fpu_pkg::RM_NEAREST, 32'h0000_0000, 1'b0));
  rows.push_back(cvt_row("i2f_one", 32'h0000_0001, fpu_pkg::RM_NEAREST, 32'h3F80_0000, 1'b0));
  rows.push_back(cvt_row("i2f_m1", 32'hFFFF_FFFF, fpu_pkg::RM_NEAREST, 32'hBF80_0000, 1'b0));
  rows.push_back(cvt_row("i2f_2p24", 32'h0100_0000, fpu_pkg::RM_ZERO, 32'h4B80_0000, 1'b0));
  rows.push_back(cvt_row("i2f_m2p31", 32'h8000_0000, fpu_pkg::RM_MINUS, 32'hCF00_0000, 1'b0));
  // 2^24+1 is a tie between even 4b800000 and 4b800001
  rows.push_back(cvt_row("p24p1_rne", 32'h0100_0001, fpu_pkg::RM_NEAREST, 32'h4B80_0000, 1'b1));
  rows.push_back(cvt_row("p24p1_rz", 32'h0100_0001, fpu_pkg::RM_ZERO, 32'h4B80_0000, 1'b1));
  rows.push_back(cvt_row("p24p1_rp", 32'h0100_0001, fpu_pkg::RM_PLUS, 32'h4B80_0001, 1'b1));
  rows.push_back(cvt_row("p24p1_rm", 32'h0100_0001, fpu_pkg::RM_MINUS, 32'h4B80_0000, 1'b1));
  // 2^24+3 ties up to the even neighbour
  rows.push_back(cvt_row("p24p3_rne", 32'h0100_0003, fpu_pkg::RM_NEAREST, 32'h4B80_0002, 1'b1));
  rows.push_back(cvt_row("p24p3_rz", 32'h0100_0003, fpu_pkg::RM_ZERO, 32'h4B80_0001, 1'b1));
  rows.push_back(cvt_row("p24p3_rp", 32'h0100_0003, fpu_pkg::RM_PLUS, 32'h4B80_0002, 1'b1));
  rows.push_back(cvt_row("p24p3_rm", 32'h0100_0003, fpu_pkg::RM_MINUS, 32'h4B80_0001, 1'b1));
  // -(2^24+1), directed modes use the sign
  rows.push_back(cvt_row("m24p1_rne", 32'hFEFF_FFFF, fpu_pkg::RM_NEAREST, 32'hCB80_0000, 1'b1));
  rows.push_back(cvt_row("m24p1_rz", 32'hFEFF_FFFF, fpu_pkg::RM_ZERO, 32'hCB80_0000, 1'b1));
  rows.push_back(cvt_row("m24p1_rp", 32'hFEFF_FFFF, fpu_pkg::RM_PLUS, 32'hCB80_0000, 1'b1));
  rows.push_back(cvt_row("m24p1_rm", 32'hFEFF_FFFF, fpu_pkg::RM_MINUS, 32'hCB80_0001, 1'b1));
  // 2^25-1 rounds up into the next binade
  rows.push_back(cvt_row("carry_rne", 32'h01FF_FFFF, fpu_pkg::RM_NEAREST, 32'h4C00_0000, 1'b1));

  ////////////////////////////////////////
  // flush during a long conversion, then a normal one
  ////////////////////////////////////////
  rows.push_back(flush_row("flush_i2f", 32'h0000_0001));
  rows.push_back(cvt_row("after_flush", 32'h0000_0007, fpu_pkg::RM_NEAREST, 32'h40E0_0000, 1'b0));
endtask

`endif

// File: tests/fpu_tb.sv
// testbench for fpu_top, runs the vector table through compare and i2f with back-pressure
module fpu_tb;

  typedef logic [8*14-1:0] name_t;  // test name of up to 14 chars

  typedef struct packed {
    name_t                name;
    fpu_pkg::fpu_opcode_u op;
    fpu_pkg::fpu_word_t   a;
    fpu_pkg::fpu_word_t   b;
    fpu_pkg::rmode_t      rm;
    logic                 flush;      // abandon this op mid-flight
    fpu_pkg::fpu_word_t   exp_word;
    fpu_pkg::fpu_flags_t  exp_flags;
    logic                 exp_cmp;
  } test_row_t;

  logic                 clk;
  logic                 rst;
  logic                 flush_i;
  fpu_pkg::fpu_opcode_u op_i;
  logic                 valid_i;
  fpu_pkg::fpu_word_t   rfa_i;
  fpu_pkg::fpu_word_t   rfb_i;
  fpu_pkg::rmode_t      round_mode_i;
  logic                 adv_i;
  logic                 ready_o;
  logic                 arith_valid_o;
  fpu_pkg::fpu_result_t result_o;
  logic                 cmp_valid_o;
  logic                 cmp_flag_o;
  fpu_pkg::fpu_flags_t  cmp_flags_o;

  test_row_t rows[$];
  int        seed;
  int        cycle_cnt;
  int        limit;       // timeout in cycles once the table is built
  int        test_errs;   // errors in the current test
  int        pass_cnt;
  int        fail_cnt;
  int        idx;

  fpu_top UUT (.*);

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // table builders
  ////////////////////////////////////////
  function automatic fpu_pkg::fpu_opcode_u cmp_opcode(input logic [2:0] cond);
    fpu_pkg::fpu_opcode_u op;
    op                = '0;
    op.cmp_view.valid = 1'b1;
    op.cmp_view.cmp   = 1'b1;
    op.cmp_view.cond  = cond;
    return op;
  endfunction

  function automatic fpu_pkg::fpu_opcode_u i2f_opcode();
    fpu_pkg::fpu_opcode_u op;
    op                  = '0;
    op.arith_view.valid = 1'b1;
    op.arith_view.cmp   = 1'b0;
    op.arith_view.code  = fpu_pkg::I2F_CODE;
    return op;
  endfunction

  function automatic test_row_t cmp_row(input name_t name, input logic [2:0] cond,
                                        input fpu_pkg::fpu_word_t a, input fpu_pkg::fpu_word_t b,
                                        input logic flag, input logic inv);
    test_row_t r;
    r                   = '0;
    r.name              = name;
    r.op                = cmp_opcode(cond);
    r.a                 = a;
    r.b                 = b;
    r.exp_cmp           = flag;
    r.exp_flags.invalid = inv;   // compare never inexact
    return r;
  endfunction

  function automatic test_row_t cvt_row(input name_t name, input fpu_pkg::fpu_word_t a,
                                        input fpu_pkg::rmode_t rm,
                                        input fpu_pkg::fpu_word_t word, input logic inexact);
    test_row_t r;
    r                   = '0;
    r.name              = name;
    r.op                = i2f_opcode();
    r.a                 = a;
    r.rm                = rm;
    r.exp_word          = word;
    r.exp_flags.inexact = inexact;
    return r;
  endfunction

  function automatic test_row_t flush_row(input name_t name, input fpu_pkg::fpu_word_t a);
    test_row_t r;
    r       = cvt_row(name, a, fpu_pkg::RM_NEAREST, '0, 1'b0);
    r.flush = 1'b1;
    return r;
  endfunction

  `include "fpu_tb_vectors.svh"

  ////////////////////////////////////////
  // typed compare tasks
  ////////////////////////////////////////
  task automatic check_word(input name_t name, input fpu_pkg::fpu_word_t exp,
                            input fpu_pkg::fpu_word_t act);
    if (exp !== act) begin
      $display("** Error %0s: result expected %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flags(input name_t name, input fpu_pkg::fpu_flags_t exp,
                             input fpu_pkg::fpu_flags_t act);
    if (exp !== act) begin
      $display("** Error %0s: flags expected %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_cmp(input name_t name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error %0s: compare flag expected %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;                    // drive and sample clear of the edge
  endtask

  task automatic apply_row(input test_row_t r);
    while (!ready_o) next_cycle();
    op_i         = r.op;
    rfa_i        = r.a;
    rfb_i        = r.b;
    round_mode_i = r.rm;
    valid_i      = 1'b1;
    next_cycle();          // accepted on this edge
    valid_i      = 1'b0;
    op_i         = '0;
    rfa_i        = '0;
    rfb_i        = '0;
  endtask

  task automatic run_flushed(input test_row_t r);
    int i;
    apply_row(r);
    repeat (3) next_cycle();   // still normalizing
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    if (!ready_o) begin
      $display("%0s: ready_o did not return high after flush", r.name);
      test_errs++;
    end
    for (i = 0; i < 36; i++) begin
      if (arith_valid_o) begin
        $display("%0s: arith_valid_o rose after the op was flushed", r.name);
        test_errs++;
      end
      next_cycle();
    end
  endtask

  task automatic run_normal(input test_row_t r);
    logic                 is_cmp;
    int                   hold;
    int                   i;
    fpu_pkg::fpu_result_t res_snap;
    logic                 flag_snap;
    fpu_pkg::fpu_flags_t  cflags_snap;
    is_cmp = r.op.cmp_view.cmp;
    hold   = 1 + ($unsigned($random(seed)) % 4);  // adv_i low this long
    apply_row(r);
    if (is_cmp && !cmp_valid_o) begin
      $display("%0s: compare result not valid one cycle after accept", r.name);
      test_errs++;
    end
    while (!(is_cmp ? cmp_valid_o : arith_valid_o)) next_cycle();
    res_snap    = result_o;
    flag_snap   = cmp_flag_o;
    cflags_snap = cmp_flags_o;
    for (i = 0; i < hold; i++) begin
      next_cycle();
      if (!(is_cmp ? cmp_valid_o : arith_valid_o) || ready_o) begin
        $display("%0s: valid dropped or ready_o rose while adv_i was low", r.name);
        test_errs++;
      end
      if (result_o !== res_snap || cmp_flag_o !== flag_snap || cmp_flags_o !== cflags_snap) begin
        $display("%0s: held result changed while adv_i was low", r.name);
        test_errs++;
      end
    end
    if (is_cmp) begin
      check_cmp(r.name, r.exp_cmp, cmp_flag_o);
      check_flags(r.name, r.exp_flags, cmp_flags_o);
    end else begin
      check_word(r.name, r.exp_word, result_o.value);
      check_flags(r.name, r.exp_flags, result_o.flags);
    end
    adv_i = 1'b1;
    next_cycle();
    adv_i = 1'b0;
    if (arith_valid_o || cmp_valid_o || !ready_o) begin
      $display("%0s: machine not back to idle after adv_i", r.name);
      test_errs++;
    end
  endtask

  task automatic finish_test(input name_t name);
    $display("%0s %0s", name, (test_errs == 0) ? "passed" : "failed");
    if (test_errs == 0) pass_cnt++;
    else fail_cnt++;
    test_errs = 0;
  endtask

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////
  always @(posedge clk) begin
    cycle_cnt++;
    if (limit > 0 && cycle_cnt >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    seed         = 32'h8287_3882;
    clk          = 1'b0;
    rst          = 1'b1;
    flush_i      = 1'b0;
    op_i         = '0;
    valid_i      = 1'b0;
    rfa_i        = '0;
    rfb_i        = '0;
    round_mode_i = fpu_pkg::RM_NEAREST;
    adv_i        = 1'b0;
    cycle_cnt    = 0;
    test_errs    = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    fill_rows();
    limit = rows.size() * 40;     // worst i2f is about 34 cycles plus holds
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;
    if (!ready_o || arith_valid_o || cmp_valid_o || cmp_flag_o) begin
      $display("reset_state: outputs not idle after reset");
      test_errs++;
    end
    finish_test("reset_state");
    for (idx = 0; idx < rows.size(); idx++) begin
      if (rows[idx].flush) run_flushed(rows[idx]);
      else run_normal(rows[idx]);
      finish_test(rows[idx].name);
    end
    $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+tests
rtl/fpu_pkg.sv
rtl/fpu_unpack.sv
rtl/fpu_compare.sv
rtl/fpu_seq_fsm.sv
rtl/fpu_norm_counter.sv
rtl/fpu_i2f_datapath.sv
rtl/fpu_top.sv
tests/fpu_tb.sv

// File: Makefile
# Verilator build and run for the fpu testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

SOURCES := $(wildcard rtl/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
